// File: src/board_pkg.sv
package board_pkg;

    // Board geometry
    // Square n sits on file n / 8 (a..h) and rank n % 8 + 1
    localparam int unsigned NUM_SQUARES = 64;
    localparam int unsigned SQ_IDX_W = 6;

    // Bus geometry
    localparam int unsigned ADDR_W = 8;
    localparam int unsigned WORD_W = 32;
    localparam int unsigned LANES = 4;
    localparam int unsigned BYTE_W = WORD_W / LANES;

    // One square's contents, or one bus data word
    typedef logic [WORD_W-1:0] word_t;

    // Square index, a1 = 0 .. h8 = 63
    typedef logic [SQ_IDX_W-1:0] sq_idx_t;

    typedef logic [ADDR_W-1:0] bus_addr_t;

    // Byte enables, bit i selects bits 8i+7..8i
    typedef logic [LANES-1:0] lane_mask_t;

    // Full word
    localparam lane_mask_t LANE_FULL = 4'b1111;

    // Half words
    localparam lane_mask_t LANE_UPPER = 4'b1100;
    localparam lane_mask_t LANE_LOWER = 4'b0011;

    // Single bytes
    localparam lane_mask_t LANE_BYTE3 = 4'b1000;
    localparam lane_mask_t LANE_BYTE2 = 4'b0100;
    localparam lane_mask_t LANE_BYTE1 = 4'b0010;
    localparam lane_mask_t LANE_BYTE0 = 4'b0001;

endpackage

// File: src/square_access_if.sv
interface square_access_if;

    import board_pkg::*;

    // Decoded write, single-cycle strobe
    logic       wr_en;
    sq_idx_t    wr_sq;
    lane_mask_t wr_lanes;
    word_t      wr_data;

    // Decoded read, level while the bus read is valid
    logic       rd_en;
    sq_idx_t    rd_sq;

    // Stored word of rd_sq, combinational
    word_t      rd_data;

    modport decoder (
        output wr_en,
        output wr_sq,
        output wr_lanes,
        output wr_data,
        output rd_en,
        output rd_sq,
        input  rd_data
    );

    modport bank (
        input  wr_en,
        input  wr_sq,
        input  wr_lanes,
        input  wr_data,
        input  rd_en,
        input  rd_sq,
        output rd_data
    );

endinterface

// File: src/bus_decode.sv
module bus_decode #(
    parameter int unsigned NUM_SQUARES = board_pkg::NUM_SQUARES
) (
    input  logic                  cs,
    input  logic                  read,
    input  logic                  write,
    input  board_pkg::lane_mask_t byte_en,
    input  board_pkg::bus_addr_t  addr,
    input  board_pkg::word_t      write_data,
    output board_pkg::word_t      read_data,
    square_access_if.decoder      acc
);

    import board_pkg::*;

    logic       addr_ok;
    logic       lanes_ok;
    logic       wr_ok;
    logic       rd_ok;
    sq_idx_t    sq;

    // Addresses 64..255 hit no square
    assign addr_ok = (addr < NUM_SQUARES);

    assign sq = addr[SQ_IDX_W-1:0];

    // Only aligned full, half and byte accesses are accepted
    always_comb begin
        case (byte_en)
            LANE_FULL,
            LANE_UPPER,
            LANE_LOWER,
            LANE_BYTE3,
            LANE_BYTE2,
            LANE_BYTE1,
            LANE_BYTE0: lanes_ok = 1'b1;
            default:    lanes_ok = 1'b0;
        endcase
    end

    assign wr_ok = cs && write && addr_ok && lanes_ok;

    // Read ignores byte enables, the whole word is returned
    assign rd_ok = cs && read && addr_ok;

    // Write port toward the bank
    assign acc.wr_en    = wr_ok;
    assign acc.wr_sq    = sq;
    assign acc.wr_lanes = byte_en;
    assign acc.wr_data  = write_data;

    // Read port toward the bank
    assign acc.rd_en = rd_ok;
    assign acc.rd_sq = sq;

    // Bank returns zero unless rd_en is high
    assign read_data = acc.rd_data;

endmodule

// File: src/square_bank.sv
module square_bank #(
    parameter int unsigned NUM_SQUARES = board_pkg::NUM_SQUARES
) (
    input  logic          CLK,
    input  logic          RESET,
    square_access_if.bank acc
);

    import board_pkg::*;

    // One word per square
    word_t squares [NUM_SQUARES];

    word_t wr_mask;
    word_t wr_old;
    word_t wr_merged;

    // Spread each lane enable over its byte
    function automatic word_t lane_bits(input lane_mask_t lanes);
        word_t bits;
        bits = '0;
        for (int l = 0; l < LANES; l++) begin
            bits[l*BYTE_W +: BYTE_W] = {BYTE_W{lanes[l]}};
        end
        return bits;
    endfunction

    assign wr_mask = lane_bits(acc.wr_lanes);
    assign wr_old  = squares[acc.wr_sq];

    // Lanes not enabled keep their stored bytes
    assign wr_merged = (wr_old & ~wr_mask) | (acc.wr_data & wr_mask);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < NUM_SQUARES; i++) begin
                squares[i] <= '0;
            end
        end else if (acc.wr_en) begin
            squares[acc.wr_sq] <= wr_merged;
        end
    end

    // Read takes the stored word, so a same-cycle write shows next cycle
    always_comb begin
        if (acc.rd_en) begin
            acc.rd_data = squares[acc.rd_sq];
        end else begin
            acc.rd_data = '0;
        end
    end

endmodule

// File: src/chess_board_regs.sv
module chess_board_regs #(
    parameter int unsigned NUM_SQUARES = board_pkg::NUM_SQUARES
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        CS,
    input  logic        READ,
    input  logic        WRITE,
    input  logic [3:0]  BYTE_EN,
    input  logic [7:0]  ADDR,
    input  logic [31:0] WRITE_DATA,
    output logic [31:0] READ_DATA
);

    // Decoded accesses between decoder and register bank
    square_access_if acc ();

    // Strobe, range and byte-enable checks
    bus_decode #(
        .NUM_SQUARES (NUM_SQUARES)
    ) u_decode (
        .cs         (CS),
        .read       (READ),
        .write      (WRITE),
        .byte_en    (BYTE_EN),
        .addr       (ADDR),
        .write_data (WRITE_DATA),
        .read_data  (READ_DATA),
        .acc        (acc)
    );

    // Square storage, a1 at 0 through h8 at 63
    square_bank #(
        .NUM_SQUARES (NUM_SQUARES)
    ) u_bank (
        .CLK   (CLK),
        .RESET (RESET),
        .acc   (acc)
    );

endmodule

// File: dv/board_model.svh
`ifndef BOARD_MODEL_SVH
`define BOARD_MODEL_SVH

// Expected contents of all 64 squares
word_t board_mem [NUM_SQUARES];

function automatic bit legal_lanes(input lane_mask_t be);
    return be inside {LANE_FULL, LANE_UPPER, LANE_LOWER,
                      LANE_BYTE3, LANE_BYTE2, LANE_BYTE1, LANE_BYTE0};
endfunction

task automatic clear_board();
    for (int i = 0; i < NUM_SQUARES; i++) begin
        board_mem[i] = '0;
    end
endtask

// Stored word while CS and READ are high and the address hits a square
function automatic word_t expected_read(input logic cs_v, input logic rd_v,
                                        input bus_addr_t addr_v);
    if (cs_v && rd_v && int'(addr_v) < NUM_SQUARES) begin
        return board_mem[addr_v[SQ_IDX_W-1:0]];
    end
    return '0;
endfunction

// Merge of the enabled byte lanes, other lanes untouched
task automatic apply_write(input logic cs_v, input logic wr_v, input lane_mask_t be,
                           input bus_addr_t addr_v, input word_t data);
    int sq;
    if (!(cs_v && wr_v)) begin
        return;
    end
    if (int'(addr_v) >= NUM_SQUARES || !legal_lanes(be)) begin
        return;
    end
    sq = int'(addr_v);
    for (int l = 0; l < LANES; l++) begin
        if (be[l]) begin
            board_mem[sq][l*BYTE_W +: BYTE_W] = data[l*BYTE_W +: BYTE_W];
        end
    end
endtask

`endif

// File: dv/tb_chess_board_regs.sv
module tb_chess_board_regs;

    import board_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int MAX_CYCLES = 10000;

    logic       CLK = 1'b0;
    logic       RESET;
    logic       CS;
    logic       READ;
    logic       WRITE;
    lane_mask_t BYTE_EN;
    bus_addr_t  ADDR;
    word_t      WRITE_DATA;
    word_t      READ_DATA;

    int    seed = 59;
    int    cycle_count = 0;
    int    checks = 0;
    int    errors = 0;
    int    tests_run = 0;
    int    test_errors = 0;
    string cur_test = "reset";

    lane_mask_t partial_pats [6] = '{LANE_UPPER, LANE_LOWER, LANE_BYTE3,
                                     LANE_BYTE2, LANE_BYTE1, LANE_BYTE0};
    lane_mask_t illegal_pats [$];

    `include "board_model.svh"

    chess_board_regs #(
        .NUM_SQUARES (NUM_SQUARES)
    ) DUT (
        .CLK        (CLK),
        .RESET      (RESET),
        .CS         (CS),
        .READ       (READ),
        .WRITE      (WRITE),
        .BYTE_EN    (BYTE_EN),
        .ADDR       (ADDR),
        .WRITE_DATA (WRITE_DATA),
        .READ_DATA  (READ_DATA)
    );

    always #5 CLK = ~CLK;

    // Watchdog on the whole run
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles during test %s", MAX_CYCLES, cur_test);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic compare(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("FAILED %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    task automatic start_test(input string name);
        cur_test = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("%s done, %0d errors", cur_test, test_errors);
    endtask

    // One bus cycle; expected value taken at the falling edge
    task automatic bus_cycle(input logic cs_v, input logic rd_v, input logic wr_v,
                             input lane_mask_t be, input bus_addr_t addr_v,
                             input word_t data);
        word_t expected;
        @(posedge CLK);
        CS <= cs_v;
        READ <= rd_v;
        WRITE <= wr_v;
        BYTE_EN <= be;
        ADDR <= addr_v;
        WRITE_DATA <= data;
        @(negedge CLK);
        expected = expected_read(cs_v, rd_v, addr_v);
        compare(cur_test, expected, READ_DATA);
        apply_write(cs_v, wr_v, be, addr_v, data);
    endtask

    task automatic read_range(input int first, input int last);
        for (int a = first; a <= last; a++) begin
            bus_cycle(1'b1, 1'b1, 1'b0, LANE_FULL, bus_addr_t'(a), rand_word());
        end
    endtask

    task automatic apply_reset();
        int cycles;
        cycles = 0;
        RESET <= 1'b1;
        while (cycles < RESET_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        RESET <= 1'b0;
        clear_board();
    endtask

    task automatic write_full_words();
        // Same-cycle read must see the old word
        for (int sq = 0; sq < NUM_SQUARES; sq++) begin
            bus_cycle(1'b1, 1'b1, 1'b1, LANE_FULL, bus_addr_t'(sq), rand_word());
        end
        read_range(0, NUM_SQUARES - 1);
    endtask

    task automatic merge_partial_writes();
        bus_addr_t a;
        for (int i = 0; i < 300; i++) begin
            a = bus_addr_t'(rand_below(NUM_SQUARES));
            bus_cycle(1'b1, 1'b0, 1'b1, partial_pats[rand_below(6)], a, rand_word());
            bus_cycle(1'b1, 1'b1, 1'b0, LANE_FULL, a, '0);
        end
        read_range(0, NUM_SQUARES - 1);
    endtask

    task automatic ignore_bad_writes();
        lane_mask_t be;
        for (int i = 0; i < 100; i++) begin
            be = illegal_pats[rand_below(illegal_pats.size())];
            bus_cycle(1'b1, 1'b0, 1'b1, be, bus_addr_t'(rand_below(NUM_SQUARES)), rand_word());
            bus_cycle(1'b1, 1'b0, 1'b1, LANE_FULL, bus_addr_t'(64 + rand_below(192)),
                      rand_word());
            bus_cycle(1'b0, 1'b0, 1'b1, LANE_FULL, bus_addr_t'(rand_below(NUM_SQUARES)),
                      rand_word());
        end
        read_range(0, 255);
    endtask

    task automatic gate_read_data();
        int sel;
        for (int i = 0; i < 200; i++) begin
            sel = rand_below(3);
            bus_cycle(sel == 1, sel == 2, 1'b0, lane_mask_t'(rand_below(16)),
                      bus_addr_t'(rand_below(256)), rand_word());
        end
    endtask

    task automatic run_random_mix();
        word_t r;
        bus_addr_t a;
        for (int i = 0; i < 3000; i++) begin
            r = rand_word();
            // Half the traffic aimed at real squares
            a = r[8] ? bus_addr_t'(rand_below(NUM_SQUARES)) : bus_addr_t'(rand_below(256));
            bus_cycle(r[0] | r[1], r[2], r[3], r[7:4], a, rand_word());
        end
    endtask

    initial begin
        RESET = 1'b1;
        CS = 1'b0;
        READ = 1'b0;
        WRITE = 1'b0;
        BYTE_EN = '0;
        ADDR = '0;
        WRITE_DATA = '0;
        for (int p = 0; p < 16; p++) begin
            if (!legal_lanes(lane_mask_t'(p))) begin
                illegal_pats.push_back(lane_mask_t'(p));
            end
        end

        apply_reset();

        start_test("reset_zero");
        read_range(0, NUM_SQUARES - 1);
        finish_test();

        start_test("full_word");
        write_full_words();
        finish_test();

        start_test("partial_merge");
        merge_partial_writes();
        finish_test();

        start_test("ignored_writes");
        ignore_bad_writes();
        finish_test();

        start_test("read_gating");
        gate_read_data();
        finish_test();

        start_test("random_mix");
        run_random_mix();
        finish_test();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: chess_board_regs.f
+incdir+dv
src/board_pkg.sv
src/square_access_if.sv
src/bus_decode.sv
src/square_bank.sv
src/chess_board_regs.sv
dv/tb_chess_board_regs.sv

// File: Makefile
# Verilator build and run of the chess board register file

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_chess_board_regs
FILELIST  = chess_board_regs.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Build, run, and pass only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
